// ==== compile.f ====
hw/rffe_pkg.sv
hw/rffe_frame_if.sv
hw/rffe_apb_regs.sv
hw/rffe_clk_gen.sv
hw/rffe_frame_ctrl.sv
hw/rffe_master.sv
dv/rffe_slave_model.sv
dv/rffe_tb.sv

// ==== Bender.yml ====
package:
  name: rffe_master

sources:
  - files:
      - hw/rffe_pkg.sv
      - hw/rffe_frame_if.sv
      - hw/rffe_apb_regs.sv
      - hw/rffe_clk_gen.sv
      - hw/rffe_frame_ctrl.sv
      - hw/rffe_master.sv
  - target: simulation
    files:
      - dv/rffe_slave_model.sv
      - dv/rffe_tb.sv

// ==== dv/rffe_tb.sv ====
// RFFE master testbench
`timescale 1ns/1ps

module rffe_tb;

   localparam int cycle_limit = 40000;

   logic        clk = 1'b0;
   logic        rst;
   logic        psel, penable, pwrite;
   logic [7:0]  paddr;
   logic [31:0] pwdata, prdata;
   logic        pready, pslverr;
   logic        sclk, sdata, sdata_en, sdata_in, done;

   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   int          starts = 0;
   int          done_cnt = 0;
   int          per_cnt = 0;
   logic        armed = 1'b0;
   logic        sclk_q = 1'b0;
   logic [7:0]  cur_div = 8'd2;
   logic [7:0]  exp_buf [16];

   rffe_master DUT (
      .clk(clk), .i_rst(rst), .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
      .i_paddr(paddr), .i_pwdata(pwdata), .o_prdata(prdata), .o_pready(pready),
      .o_pslverr(pslverr), .o_sclk(sclk), .o_sdata(sdata), .o_sdata_en(sdata_en),
      .i_sdata(sdata_in), .o_done(done)
   );

   rffe_slave_model slave (.clk(clk), .i_sclk(sclk), .i_sdata(sdata), .o_sdata(sdata_in));

   always #50 clk = ~clk;

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("error %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic apb_wr(input logic [7:0] a, input logic [31:0] d, output logic err);
      @(posedge clk);
      psel    <= 1'b1;
      pwrite  <= 1'b1;
      penable <= 1'b0;
      paddr   <= a;
      pwdata  <= d;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      err = pslverr;
      check_val("o_pready", pready, 1);
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic apb_rd(input logic [7:0] a, output logic [31:0] d);
      @(posedge clk);
      psel    <= 1'b1;
      pwrite  <= 1'b0;
      penable <= 1'b0;
      paddr   <= a;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      d = prdata;
      check_val("o_pready", pready, 1);
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   // write, expect acceptance, read back
   task automatic wr_rd_check(input string name, input logic [7:0] a, input logic [31:0] d,
                              input logic [31:0] exp);
      logic        err;
      logic [31:0] r;
      apb_wr(a, d, err);
      check_val("o_pslverr", err, 0);
      apb_rd(a, r);
      check_val(name, r, exp);
   endtask

   // write during a frame, expect rejection and the old value
   task automatic locked_wr_check(input string name, input logic [7:0] a,
                                  input logic [31:0] d, input logic [31:0] exp);
      logic        err;
      logic [31:0] r;
      apb_wr(a, d, err);
      check_val("o_pslverr", err, 1);
      apb_rd(a, r);
      check_val(name, r, exp);
   endtask

   task automatic set_random_div();
      logic [7:0] d;
      d = 8'(2 + $urandom % 15);
      wr_rd_check("reg_div", rffe_pkg::reg_div, d, d);
      cur_div = d;
   endtask

   task automatic load_buf(input int n);
      for (int i = 0; i < n; i++) begin
         exp_buf[i] = 8'($urandom);
         wr_rd_check("buffer byte", 8'(rffe_pkg::reg_data_base + 4 * i), exp_buf[i], exp_buf[i]);
      end
   endtask

   task automatic run_frame(input logic [7:0] cmd, input logic [7:0] addr);
      logic err;
      wr_rd_check("reg_cmd", rffe_pkg::reg_cmd, cmd, cmd);
      wr_rd_check("reg_addr", rffe_pkg::reg_addr, addr, addr);
      apb_wr(rffe_pkg::reg_ctrl, 1, err);
      check_val("o_pslverr", err, 0);
      starts++;
      @(negedge clk);
      while (!done) @(negedge clk);
   endtask

   ///////////////////////////////////////////////////////////////////////
   // monitors
   ///////////////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout: run exceeded %0d cycles without finishing", cycle_limit);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   always @(posedge clk) begin
      if (done) done_cnt++;
      if (!rst && !DUT.frame_bus.busy) begin
         checks++;
         assert (!sdata_en) else begin
            errors++;
            $display("sdata_en was driven while the master was not busy");
         end
      end
      if (!DUT.frame_bus.busy) begin
         armed = 1'b0;
      end else if (sclk && !sclk_q) begin
         if (armed) check_val("sclk period", per_cnt, cur_div);
         armed   = 1'b1;
         per_cnt = 1;
      end else begin
         per_cnt++;
      end
      sclk_q = sclk;
   end

   ///////////////////////////////////////////////////////////////////////
   // scenarios
   ///////////////////////////////////////////////////////////////////////

   initial begin
      logic        err;
      logic [31:0] r;
      logic [3:0]  sa;
      logic [7:0]  addr;
      logic [3:0]  bc;
      void'($urandom(32'h9ee0));
      rst     = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;

      // register access and divisor clamping
      sa = 4'($urandom);
      wr_rd_check("reg_sa", rffe_pkg::reg_sa, {28'($urandom), sa}, sa);
      load_buf(16);
      wr_rd_check("reg_div", rffe_pkg::reg_div, 0, 2);
      wr_rd_check("reg_div", rffe_pkg::reg_div, 1, 2);

      // register write, with busy lockout checks
      set_random_div();
      addr = 8'($urandom % 32);
      wr_rd_check("reg_cmd", rffe_pkg::reg_cmd, {3'b010, 5'd0}, {3'b010, 5'd0});
      wr_rd_check("reg_addr", rffe_pkg::reg_addr, addr, addr);
      apb_wr(rffe_pkg::reg_ctrl, 1, err);
      check_val("o_pslverr", err, 0);
      starts++;
      apb_rd(rffe_pkg::reg_status, r);
      check_val("reg_status", r, 1);
      locked_wr_check("reg_sa", rffe_pkg::reg_sa, ~sa, sa);
      locked_wr_check("reg_cmd", rffe_pkg::reg_cmd, {3'b011, 5'd0}, {3'b010, 5'd0});
      locked_wr_check("reg_addr", rffe_pkg::reg_addr, ~addr, addr);
      locked_wr_check("reg_div", rffe_pkg::reg_div, cur_div ^ 8'h01, cur_div);
      locked_wr_check("buffer byte", rffe_pkg::reg_data_base, ~exp_buf[0], exp_buf[0]);
      locked_wr_check("reg_ctrl", rffe_pkg::reg_ctrl, 1, 0);
      while (!done) @(negedge clk);
      check_val("slave sa", slave.sa, sa);
      check_val("slave addr", slave.addr, addr);
      check_val("write count", slave.wr_log.size(), 1);
      if (slave.wr_log.size() > 0) check_val("written byte", slave.wr_log[0], exp_buf[0]);

      // register read
      set_random_div();
      addr = 8'($urandom % 32);
      run_frame({3'b011, 5'd0}, addr);
      apb_rd(rffe_pkg::reg_data_base, r);
      check_val("read byte", r, addr ^ 8'hA5);

      // extended write
      set_random_div();
      bc = 4'($urandom);
      load_buf(int'(bc) + 1);
      run_frame({4'b0000, bc}, 8'($urandom));
      check_val("write count", slave.wr_log.size(), int'(bc) + 1);
      for (int i = 0; i <= int'(bc) && i < slave.wr_log.size(); i++)
         check_val("written byte", slave.wr_log[i], exp_buf[i]);

      // extended read
      set_random_div();
      bc   = 4'($urandom);
      addr = 8'($urandom);
      run_frame({4'b0010, bc}, addr);
      for (int i = 0; i <= int'(bc); i++) begin
         apb_rd(8'(rffe_pkg::reg_data_base + 4 * i), r);
         check_val("read byte", r, 8'((addr ^ 8'hA5) + i));
      end

      check_val("slave parity errors", slave.par_errs, 0);
      check_val("done pulses", done_cnt, starts);
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// ==== dv/rffe_slave_model.sv ====
// RFFE slave behavioral model
`timescale 1ns/1ps

module rffe_slave_model (
   input  logic clk,
   input  logic i_sclk,
   input  logic i_sdata,
   output logic o_sdata
);

   logic        sclk_q;
   logic        sdata_q;
   logic [11:0] sh;        // field being received
   logic        par;
   logic [3:0]  sa;
   logic [7:0]  cmd;
   logic [7:0]  addr;
   logic        ext;
   logic        rd;
   logic [3:0]  bc;
   logic [7:0]  tx_byte;
   int          bitn;      // falling edges since the start condition
   int          rel;
   int          nf;        // master driven fields after the command
   int          d0;        // first read data bit
   int          par_errs;
   logic [7:0]  wr_log[$];

   function automatic logic [7:0] answer(input int i);
      answer = (addr ^ 8'hA5) + 8'(i);
   endfunction

   initial begin
      o_sdata  = 1'b0;
      sclk_q   = 1'b0;
      sdata_q  = 1'b0;
      par_errs = 0;
      bitn     = 0;
      rd       = 1'b0;
      ext      = 1'b0;
      bc       = '0;
   end

   ////////////////////////////////////////////////////////////////////
   // frame decode on sclk edges seen in the clk domain
   ////////////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      if (!i_sclk && !sclk_q && i_sdata && !sdata_q) begin // start condition
         bitn = 0;
         par  = 1'b0;
         rd   = 1'b0;
         wr_log.delete();
      end else if (sclk_q && !i_sclk) begin
         if (bitn < 12) begin
            sh  = {sh[10:0], i_sdata};
            par = par ^ i_sdata;
         end else if (bitn == 12) begin
            if (i_sdata != ~par) par_errs++;
            sa   = sh[11:8];
            cmd  = sh[7:0];
            ext  = cmd[7:4] == rffe_pkg::cmd_ext_wr || cmd[7:4] == rffe_pkg::cmd_ext_rd;
            rd   = cmd[5];
            bc   = ext ? cmd[3:0] : 4'd0;
            addr = ext ? 8'h00 : {3'b000, cmd[4:0]};
            nf   = rd ? (ext ? 1 : 0) : (ext ? int'(bc) + 2 : 1);
            d0   = ext ? 23 : 14;
            par  = 1'b0;
         end else begin
            rel = bitn - 13;
            if (rel / 9 < nf) begin
               if (rel % 9 < 8) begin
                  sh  = {sh[10:0], i_sdata};
                  par = par ^ i_sdata;
               end else begin
                  if (i_sdata != ~par) par_errs++;
                  if (ext && rel / 9 == 0) addr = sh[7:0];
                  else wr_log.push_back(sh[7:0]);
                  par = 1'b0;
               end
            end
         end
         bitn++;
      end else if (!sclk_q && i_sclk) begin
         rel = bitn - d0;
         if (rd && bitn >= 13 && rel >= 0 && rel < 9 * (int'(bc) + 1)) begin
            tx_byte = answer(rel / 9);
            o_sdata <= (rel % 9 < 8) ? tx_byte[7 - rel % 9] : ~^tx_byte; // odd parity
         end else begin
            o_sdata <= 1'b0;
         end
      end
      sclk_q  = i_sclk;
      sdata_q = i_sdata;
   end

endmodule

// ==== hw/rffe_master.sv ====
// RFFE bus master top level
`timescale 1ns/1ps

module rffe_master (
   input  logic                            clk,
   input  logic                            i_rst,
   // APB
   input  logic                            i_psel,
   input  logic                            i_penable,
   input  logic                            i_pwrite,
   input  logic [rffe_pkg::apb_addr_w-1:0] i_paddr,
   input  logic [rffe_pkg::apb_data_w-1:0] i_pwdata,
   output logic [rffe_pkg::apb_data_w-1:0] o_prdata,
   output logic                            o_pready,
   output logic                            o_pslverr,
   // RFFE bus
   output logic                            o_sclk,
   output logic                            o_sdata,
   output logic                            o_sdata_en,
   input  logic                            i_sdata,
   output logic                            o_done
);

   rffe_frame_if frame_bus ();

   logic [rffe_pkg::div_w-1:0] div;
   logic                       bit_en;
   logic                       sclk_hi;
   logic                       sclk_en;

   rffe_apb_regs u_regs (
      .clk       (clk),
      .i_rst     (i_rst),
      .i_psel    (i_psel),
      .i_penable (i_penable),
      .i_pwrite  (i_pwrite),
      .i_paddr   (i_paddr),
      .i_pwdata  (i_pwdata),
      .o_prdata  (o_prdata),
      .o_pready  (o_pready),
      .o_pslverr (o_pslverr),
      .o_div     (div),
      .frame     (frame_bus)
   );

   rffe_clk_gen u_clk_gen (
      .clk       (clk),
      .i_rst     (i_rst),
      .i_div     (div),
      .i_sclk_en (sclk_en),
      .o_bit_en  (bit_en),
      .o_sclk_hi (sclk_hi),
      .o_sclk    (o_sclk)
   );

   rffe_frame_ctrl u_frame_ctrl (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_bit_en   (bit_en),
      .i_sclk_hi  (sclk_hi),
      .i_sdata    (i_sdata),
      .o_sdata    (o_sdata),
      .o_sdata_en (o_sdata_en),
      .o_sclk_en  (sclk_en),
      .o_done     (o_done),
      .frame      (frame_bus)
   );

endmodule

// ==== hw/rffe_frame_ctrl.sv ====
// RFFE frame sequencer
`timescale 1ns/1ps

module rffe_frame_ctrl (
   input  logic       clk,
   input  logic       i_rst,
   input  logic       i_bit_en,
   input  logic       i_sclk_hi,
   input  logic       i_sdata,
   output logic       o_sdata,
   output logic       o_sdata_en,
   output logic       o_sclk_en,
   output logic       o_done,
   rffe_frame_if.ctrl frame
);

   rffe_pkg::frame_phase_t phase;

   logic [3:0]                  bit_cnt;   // periods left in the field, 0 is parity
   logic                        par;       // xor of the field so far
   logic [rffe_pkg::byte_w-1:0] rx_sh;

   logic                        is_reg;
   logic                        is_ext;
   logic                        is_rd;
   logic [rffe_pkg::idx_w-1:0]  last_idx;
   logic [rffe_pkg::byte_w-1:0] cmd_byte;
   logic [rffe_pkg::sa_w+rffe_pkg::byte_w-1:0] field;
   logic                        tx_bit;

   ///////////////////////////////////////////////////////////////////////
   // command decode
   ///////////////////////////////////////////////////////////////////////

   assign is_reg = frame.cmd[7:5] == rffe_pkg::cmd_reg_wr ||
                   frame.cmd[7:5] == rffe_pkg::cmd_reg_rd;
   assign is_ext = frame.cmd[7:4] == rffe_pkg::cmd_ext_wr ||
                   frame.cmd[7:4] == rffe_pkg::cmd_ext_rd;
   assign is_rd  = frame.cmd[5];    // same bit for both read codes

   // BC+1 bytes, register access always one
   assign last_idx = is_ext ? frame.cmd[rffe_pkg::idx_w-1:0] : '0;

   // register access carries the 5-bit address in the command byte
   assign cmd_byte = is_reg ? {frame.cmd[7:5], frame.addr[4:0]} : frame.cmd;

   ///////////////////////////////////////////////////////////////////////
   // transmit bit select, msb first
   ///////////////////////////////////////////////////////////////////////

   always_comb begin
      case (phase)
         rffe_pkg::sa_cmd: field = {frame.sa, cmd_byte};
         rffe_pkg::addr:   field = {{rffe_pkg::sa_w{1'b0}}, frame.addr};
         default:          field = {{rffe_pkg::sa_w{1'b0}}, frame.buf_rdata};
      endcase
   end

   assign tx_bit = field[bit_cnt - 4'd1];

   always_comb begin
      o_sdata    = 1'b0;
      o_sdata_en = 1'b0;
      case (phase)
         rffe_pkg::ssc: begin
            o_sdata    = bit_cnt[0];    // high then low
            o_sdata_en = 1'b1;
         end
         rffe_pkg::sa_cmd, rffe_pkg::addr: begin
            o_sdata    = (bit_cnt == '0) ? ~par : tx_bit;
            o_sdata_en = 1'b1;
         end
         rffe_pkg::data: begin
            if (!is_rd) begin
               o_sdata    = (bit_cnt == '0) ? ~par : tx_bit;
               o_sdata_en = 1'b1;
            end
         end
         // drive low, release in the second half
         rffe_pkg::park, rffe_pkg::end_park: o_sdata_en = i_sclk_hi;
         default: ;
      endcase
   end

   assign o_sclk_en = phase != rffe_pkg::idle && phase != rffe_pkg::ssc;

   ///////////////////////////////////////////////////////////////////////
   // sequencer
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (i_rst) begin
         phase         <= rffe_pkg::idle;
         bit_cnt       <= '0;
         par           <= 1'b0;
         frame.busy    <= 1'b0;
         frame.buf_idx <= '0;
         o_done        <= 1'b0;
      end else begin
         o_done <= 1'b0;
         if (frame.start)
            frame.busy <= 1'b1;

         if (i_bit_en) begin
            if (bit_cnt != '0) begin
               bit_cnt <= bit_cnt - 1'b1;
               par     <= par ^ tx_bit;
            end else begin
               par <= 1'b0;   // new field
            end

            case (phase)
               rffe_pkg::idle: begin
                  if (frame.busy) begin   // start pending, align to a period
                     phase         <= rffe_pkg::ssc;
                     bit_cnt       <= 4'd1;
                     frame.buf_idx <= '0;
                  end
               end
               rffe_pkg::ssc: begin
                  if (bit_cnt == '0) begin
                     phase   <= rffe_pkg::sa_cmd;
                     bit_cnt <= 4'(rffe_pkg::sa_w + rffe_pkg::byte_w);
                  end
               end
               rffe_pkg::sa_cmd: begin
                  if (bit_cnt == '0) begin
                     if (is_ext) begin
                        phase   <= rffe_pkg::addr;
                        bit_cnt <= 4'(rffe_pkg::byte_w);
                     end else if (is_reg && is_rd) begin
                        phase <= rffe_pkg::park;
                     end else if (is_reg) begin
                        phase   <= rffe_pkg::data;
                        bit_cnt <= 4'(rffe_pkg::byte_w);
                     end else begin
                        phase <= rffe_pkg::end_park;   // unsupported command
                     end
                  end
               end
               rffe_pkg::addr: begin
                  if (bit_cnt == '0) begin
                     if (is_rd) begin
                        phase <= rffe_pkg::park;
                     end else begin
                        phase   <= rffe_pkg::data;
                        bit_cnt <= 4'(rffe_pkg::byte_w);
                     end
                  end
               end
               rffe_pkg::park: begin
                  phase   <= rffe_pkg::data;
                  bit_cnt <= 4'(rffe_pkg::byte_w);
               end
               rffe_pkg::data: begin
                  if (bit_cnt == '0) begin
                     if (frame.buf_idx == last_idx) begin
                        phase <= rffe_pkg::end_park;
                     end else begin
                        frame.buf_idx <= frame.buf_idx + 1'b1;
                        bit_cnt       <= 4'(rffe_pkg::byte_w);
                     end
                  end
               end
               rffe_pkg::end_park: begin
                  phase      <= rffe_pkg::idle;
                  frame.busy <= 1'b0;
                  o_done     <= 1'b1;
               end
               default: phase <= rffe_pkg::idle;
            endcase
         end
      end
   end

   // read capture, sampled at the end of each period
   always_ff @(posedge clk) begin
      if (i_bit_en && phase == rffe_pkg::data && bit_cnt != '0)
         rx_sh <= {rx_sh[rffe_pkg::byte_w-2:0], i_sdata};
   end

   // slave parity slot, byte is complete
   assign frame.buf_we    = i_bit_en && phase == rffe_pkg::data && is_rd && bit_cnt == '0;
   assign frame.buf_wdata = rx_sh;
   assign frame.done      = o_done;

   // outside a frame the sequencer sits in idle with the bus released
   a_idle_quiet: assert property (@(posedge clk) disable iff (i_rst)
      !frame.busy |-> phase == rffe_pkg::idle && !o_sdata_en);

   a_done_src: assert property (@(posedge clk) disable iff (i_rst)
      o_done |-> $past(phase) == rffe_pkg::end_park && phase == rffe_pkg::idle);

endmodule

// ==== hw/rffe_clk_gen.sv ====
// RFFE bit clock generator
`timescale 1ns/1ps

module rffe_clk_gen (
   input  logic                       clk,
   input  logic                       i_rst,
   input  logic [rffe_pkg::div_w-1:0] i_div,
   input  logic                       i_sclk_en,
   output logic                       o_bit_en,
   output logic                       o_sclk_hi,
   output logic                       o_sclk
);

   logic [rffe_pkg::div_w-1:0] cnt;       // counts i_div-1 down to 0
   logic                       sclk_en_q;
   logic                       sclk_rise;

   assign sclk_rise = i_sclk_en & ~sclk_en_q;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         cnt       <= '0;
         sclk_en_q <= 1'b0;
      end else begin
         sclk_en_q <= i_sclk_en;
         if (cnt == '0)
            cnt <= i_div - 1'b1;    // next bit period
         else if (sclk_rise)
            cnt <= i_div - 2'd2;    // rise cycle counts as the first of the period
         else
            cnt <= cnt - 1'b1;
      end
   end

   // last cycle of a period
   assign o_bit_en = (cnt == '0);

   // high half first, odd divisors give the extra cycle to the high half
   assign o_sclk_hi = (cnt >= (i_div >> 1));

   assign o_sclk = i_sclk_en & o_sclk_hi;

endmodule

// ==== hw/rffe_apb_regs.sv ====
// RFFE master APB register block
`timescale 1ns/1ps

module rffe_apb_regs (
   input  logic                            clk,
   input  logic                            i_rst,
   input  logic                            i_psel,
   input  logic                            i_penable,
   input  logic                            i_pwrite,
   input  logic [rffe_pkg::apb_addr_w-1:0] i_paddr,
   input  logic [rffe_pkg::apb_data_w-1:0] i_pwdata,
   output logic [rffe_pkg::apb_data_w-1:0] o_prdata,
   output logic                            o_pready,
   output logic                            o_pslverr,
   output logic [rffe_pkg::div_w-1:0]      o_div,
   rffe_frame_if.regs                      frame
);

   logic                        wr_acc;     // write in access phase
   logic                        wr_ok;      // write accepted
   logic                        buf_sel;
   logic                        locked_sel; // settings frozen during a frame
   logic [rffe_pkg::idx_w-1:0]  apb_idx;
   logic [rffe_pkg::div_w-1:0]  div_wr;

   logic [2**rffe_pkg::idx_w-1:0][rffe_pkg::byte_w-1:0] buf_mem;

   ///////////////////////////////////////////////////////////////////////
   // access decode
   ///////////////////////////////////////////////////////////////////////

   assign wr_acc  = i_psel & i_penable & i_pwrite;
   assign wr_ok   = wr_acc & ~frame.busy;
   assign apb_idx = i_paddr[rffe_pkg::idx_w+1:2];
   assign div_wr  = i_pwdata[rffe_pkg::div_w-1:0];

   // 0x40..0x7C
   assign buf_sel = i_paddr[rffe_pkg::apb_addr_w-1:rffe_pkg::idx_w+2] ==
                    rffe_pkg::reg_data_base[rffe_pkg::apb_addr_w-1:rffe_pkg::idx_w+2];

   assign locked_sel = buf_sel || i_paddr inside {rffe_pkg::reg_ctrl, rffe_pkg::reg_div,
                                                  rffe_pkg::reg_sa, rffe_pkg::reg_cmd,
                                                  rffe_pkg::reg_addr};

   assign o_pready  = 1'b1; // no wait states
   assign o_pslverr = wr_acc & frame.busy & locked_sel;

   ///////////////////////////////////////////////////////////////////////
   // settings and start
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_div       <= rffe_pkg::div_min;
         frame.sa    <= '0;
         frame.cmd   <= '0;
         frame.addr  <= '0;
         frame.start <= 1'b0;
      end else begin
         frame.start <= wr_ok && i_paddr == rffe_pkg::reg_ctrl && i_pwdata[0];
         if (wr_ok) begin
            case (i_paddr)
               rffe_pkg::reg_div:
                  o_div <= (div_wr < rffe_pkg::div_min) ? rffe_pkg::div_min : div_wr;
               rffe_pkg::reg_sa:   frame.sa   <= i_pwdata[rffe_pkg::sa_w-1:0];
               rffe_pkg::reg_cmd:  frame.cmd  <= i_pwdata[rffe_pkg::byte_w-1:0];
               rffe_pkg::reg_addr: frame.addr <= i_pwdata[rffe_pkg::byte_w-1:0];
               default: ;
            endcase
         end
      end
   end

   // data buffer, read bytes from the frame take the port while busy
   always_ff @(posedge clk) begin
      if (frame.buf_we)
         buf_mem[frame.buf_idx] <= frame.buf_wdata;
      else if (wr_ok && buf_sel)
         buf_mem[apb_idx] <= i_pwdata[rffe_pkg::byte_w-1:0];
   end

   assign frame.buf_rdata = buf_mem[frame.buf_idx];

   ///////////////////////////////////////////////////////////////////////
   // read mux
   ///////////////////////////////////////////////////////////////////////

   always_comb begin
      o_prdata = '0;
      if (buf_sel) begin
         o_prdata[rffe_pkg::byte_w-1:0] = buf_mem[apb_idx];
      end else begin
         case (i_paddr)
            rffe_pkg::reg_status: o_prdata[0]                      = frame.busy;
            rffe_pkg::reg_div:    o_prdata[rffe_pkg::div_w-1:0]    = o_div;
            rffe_pkg::reg_sa:     o_prdata[rffe_pkg::sa_w-1:0]     = frame.sa;
            rffe_pkg::reg_cmd:    o_prdata[rffe_pkg::byte_w-1:0]   = frame.cmd;
            rffe_pkg::reg_addr:   o_prdata[rffe_pkg::byte_w-1:0]   = frame.addr;
            default: ;
         endcase
      end
   end

   // only the frame write-back may touch the buffer during a frame
   a_buf_locked: assert property (@(posedge clk) disable iff (i_rst)
      frame.busy && !frame.buf_we |=> $stable(buf_mem));

   // busy ends in the same cycle the done pulse appears
   a_done_busy: assert property (@(posedge clk) disable iff (i_rst)
      frame.done |-> $fell(frame.busy));

endmodule

// ==== hw/rffe_frame_if.sv ====
// Register block to frame controller link
`timescale 1ns/1ps

interface rffe_frame_if;

   // frame request, held stable while busy
   logic                        start;      // one-cycle pulse
   logic [rffe_pkg::sa_w-1:0]   sa;
   logic [rffe_pkg::byte_w-1:0] cmd;
   logic [rffe_pkg::byte_w-1:0] addr;

   // frame status
   logic                        busy;
   logic                        done;       // one-cycle pulse

   // data buffer port
   logic [rffe_pkg::idx_w-1:0]  buf_idx;
   logic [rffe_pkg::byte_w-1:0] buf_rdata;  // byte at buf_idx
   logic                        buf_we;     // read data write-back
   logic [rffe_pkg::byte_w-1:0] buf_wdata;

   modport regs (
      output start, sa, cmd, addr, buf_rdata,
      input  busy, done, buf_idx, buf_we, buf_wdata
   );

   modport ctrl (
      input  start, sa, cmd, addr, buf_rdata,
      output busy, done, buf_idx, buf_we, buf_wdata
   );

endinterface

// ==== hw/rffe_pkg.sv ====
// RFFE master shared definitions
package rffe_pkg;

   ////////////////////////////////////////////////////////////////////
   // widths
   ////////////////////////////////////////////////////////////////////

   localparam int unsigned div_w      = 8;   // bit period divisor
   localparam int unsigned sa_w       = 4;   // slave address
   localparam int unsigned byte_w     = 8;
   localparam int unsigned idx_w      = 4;   // 16-byte data buffer
   localparam int unsigned apb_addr_w = 8;
   localparam int unsigned apb_data_w = 32;

   ////////////////////////////////////////////////////////////////////
   // APB register map
   ////////////////////////////////////////////////////////////////////

   localparam logic [apb_addr_w-1:0] reg_ctrl      = 8'h00; // bit 0 starts a frame
   localparam logic [apb_addr_w-1:0] reg_status    = 8'h04; // bit 0 busy
   localparam logic [apb_addr_w-1:0] reg_div       = 8'h08;
   localparam logic [apb_addr_w-1:0] reg_sa        = 8'h0C;
   localparam logic [apb_addr_w-1:0] reg_cmd       = 8'h10;
   localparam logic [apb_addr_w-1:0] reg_addr      = 8'h14;
   localparam logic [apb_addr_w-1:0] reg_data_base = 8'h40; // byte n at base + 4n

   ////////////////////////////////////////////////////////////////////
   // command codes
   ////////////////////////////////////////////////////////////////////

   // register access, upper three bits, low five carry the address
   localparam logic [2:0] cmd_reg_wr = 3'b010;
   localparam logic [2:0] cmd_reg_rd = 3'b011;

   // extended access, upper nibble, low nibble is BC
   localparam logic [3:0] cmd_ext_wr = 4'b0000;
   localparam logic [3:0] cmd_ext_rd = 4'b0010;

   // slowest sclk is clk/255, fastest clk/2
   localparam logic [div_w-1:0] div_min = 8'd2;

   ////////////////////////////////////////////////////////////////////
   // frame sequencer phases
   ////////////////////////////////////////////////////////////////////

   typedef enum logic [2:0] {
      idle,
      ssc,       // sequence start condition, sclk low
      sa_cmd,    // slave address, command, parity
      addr,      // extended address byte and parity
      park,      // turnaround before read data
      data,      // data bytes with parity
      end_park   // closing bus park
   } frame_phase_t;

endpackage
